/* rtl/stuff_params.svh */
`ifndef STUFF_PARAMS_SVH
`define STUFF_PARAMS_SVH

`define STUFF_LANE_DEPTH 4   // entries per byte lane
`define STUFF_OUT_DEPTH  16  // escaped words waiting for the host
`define STUFF_OUT_ROOM   6   // max output fill that still takes a data write
`define STUFF_ADR_W      3   // word address bits
`define STUFF_CNT_W      16  // segment byte counters

`endif

/* rtl/stuff_pkg.sv */
package stuff_pkg;

    // one byte in a lane FIFO, flag precomputed at write
    typedef struct packed {
        logic       ff;     // byte is 0xff
        logic [7:0] data;
    } lane_byte_t;

    // escaped word as queued for the host
    typedef struct packed {
        logic [31:0] data;  // msb aligned
        logic [1:0]  bytes; // 0 means 4
    } out_word_t;

    // 2-bit byte count to number of bytes
    function automatic logic [2:0] byte_count(input logic [1:0] bytes);
        return (bytes == 2'd0) ? 3'd4 : {1'b0, bytes};
    endfunction

endpackage

/* rtl/wb_pkg.sv */
`include "stuff_params.svh"

package wb_pkg;

    typedef enum logic [`STUFF_ADR_W-1:0] {
        REG_DATA      = 0, // wr pushes input word, rd pops escaped word
        REG_BYTES     = 1, // byte count for following data writes
        REG_FLUSH     = 2,
        REG_STATUS    = 3, // {flush_done, head bytes, nempty}
        REG_IN_TOTAL  = 4,
        REG_OUT_TOTAL = 5
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ROOM,      // data write held off, no room downstream
        ST_ACK
    } ctrl_state_e;

endpackage

/* rtl/stream_if.sv */
`timescale 1ns/100ps

interface stream_if;
    logic [31:0] data;   // msb aligned
    logic [1:0]  bytes;  // 0 means 4
    logic        valid;
    logic        flush;  // end of segment

    modport src (
        output data, bytes, valid, flush
    );

    modport snk (
        input data, bytes, valid, flush
    );

    // passive tap, e.g. statistics
    modport mon (
        input data, bytes, valid, flush
    );
endinterface

/* rtl/stream_fifo.sv */
`timescale 1ns/100ps

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic                   xclk,
    input  logic                   rst,
    input  logic                   wr,
    input  T                       wdata,
    input  logic                   rd,
    output T                       rdata,
    output logic                   nempty,
    output logic [$clog2(DEPTH):0] level
);
    localparam int PTR_W = $clog2(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    always_ff @(posedge xclk) begin
        if (wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign rdata  = mem[rd_ptr]; // head visible without a read
    assign nempty = (level != '0);

    // the callers' flow control must keep these away
    a_no_overflow: assert property (@(posedge xclk) disable iff (rst)
        wr |-> (int'(level) < DEPTH));
    a_no_underflow: assert property (@(posedge xclk) disable iff (rst)
        rd |-> nempty);

endmodule

/* rtl/ff_escape.sv */
`timescale 1ns/100ps
`include "stuff_params.svh"

module ff_escape import stuff_pkg::*; (
    input  logic  xclk,
    input  logic  rst,
    stream_if.snk in_s,
    stream_if.src out_s,
    output logic  in_ready
);
    localparam int LVL_W = $clog2(`STUFF_LANE_DEPTH) + 1;

    lane_byte_t       lane_wdata [4];
    lane_byte_t       lane_rdata [4];
    logic [3:0]       lane_wr;
    logic [3:0]       lane_rd;
    logic [3:0]       lane_nempty;
    logic [LVL_W-1:0] lane_level [4];

    logic [1:0]  wr_ptr;      // next input byte goes to lane 3 - wr_ptr
    logic [1:0]  rd_ptr;      // next output byte comes from lane 3 - rd_ptr
    logic        cry_ff;      // zero still owed for a 0xff that ended last word
    logic        flush_pend;
    logic [1:0]  flush_dly;

    lane_byte_t  byte_b [4];  // lanes rotated so [3] is the next byte
    logic [3:0]  ne_b;

    logic [31:0] word_w;
    logic [2:0]  filled_w;    // output positions that got a byte or a zero
    logic [2:0]  taken_w;     // lane bytes consumed
    logic [2:0]  zeros_w;     // zeros inserted
    logic        cry_w;
    logic [3:0]  rd_mask_w;
    logic        rdy_w;
    logic        flush_last;
    logic        emit;

    // rotate input bytes onto the lanes, continuing where the last word stopped
    always_comb begin : wr_lanes
        logic [1:0] j;
        for (int l = 0; l < 4; l++) begin
            j = 2'(3 - l) - wr_ptr;  // input byte index, 0 is msb
            lane_wdata[l].data = in_s.data[8*(3-j) +: 8];
            lane_wdata[l].ff   = &in_s.data[8*(3-j) +: 8];
            lane_wr[l]         = in_s.valid && ({1'b0, j} < byte_count(in_s.bytes));
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_lane
        stream_fifo #(
            .T     (lane_byte_t),
            .DEPTH (`STUFF_LANE_DEPTH)
        ) u_lane (
            .xclk   (xclk),
            .rst    (rst),
            .wr     (lane_wr[i]),
            .wdata  (lane_wdata[i]),
            .rd     (lane_rd[i]),
            .rdata  (lane_rdata[i]),
            .nempty (lane_nempty[i]),
            .level  (lane_level[i])
        );
    end

    // need two free entries in every lane
    always_comb begin
        in_ready = 1'b1;
        for (int l = 0; l < 4; l++) begin
            if (lane_level[l] > LVL_W'(`STUFF_LANE_DEPTH - 2)) begin
                in_ready = 1'b0;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            byte_b[k] = lane_rdata[2'(k) - rd_ptr];
            ne_b[k]   = lane_nempty[2'(k) - rd_ptr];
        end
    end

    // fill output positions msb first, each from the next lane byte or a zero
    always_comb begin : sel_bytes
        logic       z;
        logic [1:0] b;
        z         = cry_ff;
        taken_w   = '0;
        filled_w  = '0;
        zeros_w   = '0;
        word_w    = '0;
        rd_mask_w = '0;
        for (int k = 3; k >= 0; k--) begin
            b = 2'(3'd3 - taken_w);
            if (z) begin
                z        = 1'b0;       // escape zero
                zeros_w  = zeros_w + 3'd1;
                filled_w = filled_w + 3'd1;
            end else if (ne_b[b]) begin
                word_w[8*k +: 8]     = byte_b[b].data;
                z                    = byte_b[b].ff;
                rd_mask_w[b - rd_ptr] = 1'b1;
                taken_w              = taken_w + 3'd1;
                filled_w             = filled_w + 3'd1;
            end
        end
        cry_w = z;                     // only set when the word is full
    end

    assign rdy_w      = (filled_w == 3'd4);
    assign flush_last = flush_pend && !rdy_w;
    assign emit       = rdy_w || (flush_last && (cry_ff || (|lane_nempty)));
    assign lane_rd    = emit ? rd_mask_w : 4'b0000;

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            cry_ff      <= 1'b0;
            flush_pend  <= 1'b0;
            flush_dly   <= '0;
            out_s.valid <= 1'b0;
            out_s.flush <= 1'b0;
        end else begin
            if (in_s.valid) begin
                wr_ptr <= wr_ptr + in_s.bytes; // count mod 4
            end
            if (emit) begin
                rd_ptr <= rd_ptr + 2'(taken_w);
                cry_ff <= cry_w;
            end
            if (in_s.flush) begin
                flush_pend <= 1'b1;
            end else if (flush_last) begin
                flush_pend <= 1'b0;
            end
            flush_dly   <= {flush_dly[0], flush_last};
            out_s.valid <= emit;
            out_s.flush <= flush_dly[1];  // two cycles behind the last word
        end
    end

    always_ff @(posedge xclk) begin
        if (emit) begin
            out_s.data  <= word_w;
            out_s.bytes <= filled_w[1:0];
        end
    end

    // a full word uses 4 - zeros lane bytes
    a_ptr_zeros: assert property (@(posedge xclk) disable iff (rst)
        (emit && rdy_w) |=> (rd_ptr == $past(rd_ptr) - $past(2'(zeros_w))));
    a_no_valid_in_rst: assert property (@(posedge xclk)
        rst |=> !out_s.valid);

endmodule

/* rtl/stuff_byte_counter.sv */
`timescale 1ns/100ps
`include "stuff_params.svh"

module stuff_byte_counter import stuff_pkg::*; (
    input  logic                    xclk,
    input  logic                    rst,
    stream_if.mon                   in_s,
    stream_if.mon                   out_s,
    output logic [`STUFF_CNT_W-1:0] in_total,
    output logic [`STUFF_CNT_W-1:0] out_total
);
    localparam int CNT_W = `STUFF_CNT_W;

    logic [CNT_W-1:0] in_sum;
    logic [CNT_W-1:0] out_sum;
    logic [CNT_W-1:0] in_add;
    logic [CNT_W-1:0] out_add;

    assign in_add  = in_s.valid  ? CNT_W'(byte_count(in_s.bytes))  : '0;
    assign out_add = out_s.valid ? CNT_W'(byte_count(out_s.bytes)) : '0;

    always_ff @(posedge xclk) begin
        if (rst) begin
            in_sum    <= '0;
            out_sum   <= '0;
            in_total  <= '0;
            out_total <= '0;
        end else if (out_s.flush) begin
            in_total  <= in_sum;       // segment closed
            out_total <= out_sum;
            in_sum    <= in_add;       // next segment may already start
            out_sum   <= out_add;
        end else begin
            in_sum  <= in_sum + in_add;
            out_sum <= out_sum + out_add;
        end
    end

endmodule

/* rtl/wb_stuff_ctrl.sv */
`timescale 1ns/100ps
`include "stuff_params.svh"

module wb_stuff_ctrl import stuff_pkg::*, wb_pkg::*; (
    input  logic                    xclk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`STUFF_ADR_W-1:0] wb_adr,
    input  logic [31:0]             wb_wdata,
    output logic [31:0]             wb_rdata,
    output logic                    wb_ack,
    stream_if.src                   in_s,
    stream_if.snk                   out_s,
    input  logic                    in_ready,
    input  logic [`STUFF_CNT_W-1:0] in_total,
    input  logic [`STUFF_CNT_W-1:0] out_total
);
    localparam int LVL_W = $clog2(`STUFF_OUT_DEPTH) + 1;

    ctrl_state_e      state;
    reg_addr_e        adr;
    logic             req;
    logic             room;
    logic             data_wr;
    logic             data_rd;
    logic             flush_wr;
    logic [1:0]       bytes_reg;   // 0 means 4
    logic             flush_done;
    out_word_t        push_word;
    out_word_t        head;
    logic             out_nempty;
    logic [LVL_W-1:0] out_level;

    assign adr  = reg_addr_e'(wb_adr);
    assign req  = wb_cyc && wb_stb;
    // worst case drain of all lanes must still fit the output FIFO
    assign room = in_ready && (out_level <= LVL_W'(`STUFF_OUT_ROOM));

    always_ff @(posedge xclk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= (wb_we && (adr == REG_DATA) && !room) ?
                                 ST_WAIT_ROOM : ST_ACK;
                    end
                end
                ST_WAIT_ROOM: begin
                    if (!req) begin
                        state <= ST_IDLE;   // master gave up
                    end else if (room) begin
                        state <= ST_ACK;
                    end
                end
                default: state <= ST_IDLE;  // ack lasts one cycle
            endcase
        end
    end

    assign wb_ack   = (state == ST_ACK);
    assign data_wr  = wb_ack && wb_we && (adr == REG_DATA);
    assign data_rd  = wb_ack && !wb_we && (adr == REG_DATA) && out_nempty;
    assign flush_wr = wb_ack && wb_we && (adr == REG_FLUSH);

    assign in_s.data  = wb_wdata;
    assign in_s.bytes = bytes_reg;
    assign in_s.valid = data_wr;
    assign in_s.flush = flush_wr;

    always_ff @(posedge xclk) begin
        if (rst) begin
            bytes_reg  <= 2'd0;
            flush_done <= 1'b0;
        end else begin
            if (wb_ack && wb_we && (adr == REG_BYTES)) begin
                bytes_reg <= wb_wdata[1:0];
            end
            if (flush_wr) begin
                flush_done <= 1'b0;
            end else if (out_s.flush) begin
                flush_done <= 1'b1;
            end
        end
    end

    assign push_word = '{data: out_s.data, bytes: out_s.bytes};

    stream_fifo #(
        .T     (out_word_t),
        .DEPTH (`STUFF_OUT_DEPTH)
    ) u_out_fifo (
        .xclk   (xclk),
        .rst    (rst),
        .wr     (out_s.valid),
        .wdata  (push_word),
        .rd     (data_rd),
        .rdata  (head),
        .nempty (out_nempty),
        .level  (out_level)
    );

    always_comb begin
        case (adr)
            REG_DATA:      wb_rdata = out_nempty ? head.data : 32'd0;
            REG_BYTES:     wb_rdata = {30'd0, bytes_reg};
            REG_STATUS:    wb_rdata = {28'd0, flush_done,
                                       (out_nempty ? head.bytes : 2'd0), out_nempty};
            REG_IN_TOTAL:  wb_rdata = 32'(in_total);
            REG_OUT_TOTAL: wb_rdata = 32'(out_total);
            default:       wb_rdata = 32'd0;
        endcase
    end

    // master holds cyc and stb until it sees ack
    a_ack_in_cycle: assert property (@(posedge xclk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

/* rtl/stuff_top.sv */
`timescale 1ns/100ps
`include "stuff_params.svh"

module stuff_top (
    input  logic                    xclk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`STUFF_ADR_W-1:0] wb_adr,
    input  logic [31:0]             wb_wdata,
    output logic [31:0]             wb_rdata,
    output logic                    wb_ack
);
    logic                    in_ready;
    logic [`STUFF_CNT_W-1:0] in_total;
    logic [`STUFF_CNT_W-1:0] out_total;

    stream_if in_s ();   // host words into the escaper
    stream_if out_s ();  // escaped words back to the host side

    wb_stuff_ctrl u_ctrl (
        .xclk      (xclk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .in_s      (in_s),
        .out_s     (out_s),
        .in_ready  (in_ready),
        .in_total  (in_total),
        .out_total (out_total)
    );

    ff_escape u_escape (
        .xclk     (xclk),
        .rst      (rst),
        .in_s     (in_s),
        .out_s    (out_s),
        .in_ready (in_ready)
    );

    stuff_byte_counter u_counter (
        .xclk      (xclk),
        .rst       (rst),
        .in_s      (in_s),
        .out_s     (out_s),
        .in_total  (in_total),
        .out_total (out_total)
    );

endmodule

/* tb/tb_stuff_top.sv */
`timescale 1ns/100ps
`include "stuff_params.svh"

module tb_stuff_top
    import wb_pkg::*;
();
    localparam int ACK_TIMEOUT = 50;      // cycles for an ordinary access
    localparam int STALL_LIMIT = 20;      // data write is dropped and retried after this
    localparam int MAX_RETRY   = 40;
    localparam int FLUSH_POLLS = 40;
    localparam int DRAIN_WORDS = 64;
    localparam int RUN_CYCLES  = 200000;

    logic                    xclk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`STUFF_ADR_W-1:0] wb_adr;
    logic [31:0]             wb_wdata;
    logic [31:0]             wb_rdata;
    logic                    wb_ack;

    logic [7:0] exp_q [$];   // reference byte stream of the segment
    logic [7:0] got_q [$];   // bytes read back from the DUT
    int         in_cnt;
    int         ff_cnt;
    int         last_cnt;    // byte count of the last popped word
    int         cur_bytes;   // mirror of the BYTES register
    int         stalls;
    int         errors;
    int         timeouts;
    int         seed;

    stuff_top u_dut (
        .xclk     (xclk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    initial xclk = 1'b0;
    always #20 xclk = ~xclk;

    initial begin
        repeat (RUN_CYCLES) @(posedge xclk);
        $display("simulation still running after %0d cycles, stopped", RUN_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // one classic cycle with ack sampled on the falling edge
    task automatic run_cycle(input logic [`STUFF_ADR_W-1:0] adr, input logic we,
                             input logic [31:0] wdata, input int limit,
                             output logic [31:0] rdata, output logic acked);
        int waited;
        waited = 0;
        rdata  = 32'd0;
        @(posedge xclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        @(negedge xclk);
        while (!wb_ack && waited < limit) begin
            @(negedge xclk);
            waited++;
        end
        acked = wb_ack;
        if (acked) begin
            rdata = wb_rdata;
        end
        @(posedge xclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [`STUFF_ADR_W-1:0] adr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        acked;
        run_cycle(adr, 1'b1, wdata, ACK_TIMEOUT, rdata, acked);
        if (!acked) begin
            $display("write to register %0d got no acknowledge within %0d cycles",
                     adr, ACK_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic wb_read(input logic [`STUFF_ADR_W-1:0] adr, output logic [31:0] rdata);
        logic acked;
        run_cycle(adr, 1'b0, 32'd0, ACK_TIMEOUT, rdata, acked);
        if (!acked) begin
            $display("read of register %0d got no acknowledge within %0d cycles",
                     adr, ACK_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic clear_model();
        exp_q.delete();
        got_q.delete();
        in_cnt   = 0;
        ff_cnt   = 0;
        last_cnt = 0;
    endtask

    // every 0xff in the reference gets a stuffed zero after it
    task automatic add_expected(input logic [31:0] word, input int nbytes);
        logic [7:0] b;
        for (int i = 0; i < nbytes; i++) begin
            b = word[31-8*i -: 8];
            exp_q.push_back(b);
            in_cnt++;
            if (b == 8'hff) begin
                exp_q.push_back(8'h00);
                ff_cnt++;
            end
        end
    endtask

    task automatic drain_output();
        logic [31:0] st;
        logic [31:0] w;
        int          n;
        int          words;
        words = 0;
        wb_read(REG_STATUS, st);
        while (st[0] && words < DRAIN_WORDS) begin
            n = int'(st[2:1]);
            if (n == 0) begin
                n = 4;
            end
            wb_read(REG_DATA, w);
            for (int i = 0; i < n; i++) begin
                got_q.push_back(w[31-8*i -: 8]);   // msb first
            end
            last_cnt = n;
            words++;
            wb_read(REG_STATUS, st);
        end
        if (st[0]) begin
            $display("output FIFO still not empty after %0d reads", DRAIN_WORDS);
            timeouts++;
        end
    endtask

    task automatic send_word(input logic [31:0] word, input int nbytes);
        logic [31:0] rdata;
        logic        acked;
        int          tries;
        if (nbytes != cur_bytes) begin
            wb_write(REG_BYTES, 32'(nbytes % 4));  // 4 bytes coded as 0
            cur_bytes = nbytes;
        end
        acked = 1'b0;
        tries = 0;
        while (!acked && tries < MAX_RETRY) begin
            run_cycle(REG_DATA, 1'b1, word, STALL_LIMIT, rdata, acked);
            if (!acked) begin
                stalls++;
                drain_output();   // make room and retry the same word
            end
            tries++;
        end
        if (acked) begin
            add_expected(word, nbytes);
        end else begin
            $display("data write of %08h never acknowledged after %0d tries", word, tries);
            timeouts++;
        end
    endtask

    task automatic close_segment(input string name);
        logic [31:0] st;
        logic [31:0] w;
        logic [31:0] in_tot;
        logic [31:0] out_tot;
        int          polls;
        int          exp_last;
        wb_write(REG_FLUSH, 32'd0);
        polls = 0;
        wb_read(REG_STATUS, st);
        while (!st[3] && polls < FLUSH_POLLS) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (!st[3]) begin
            $display("%s: flush-done flag never set after the flush", name);
            timeouts++;
        end
        drain_output();
        wb_read(REG_DATA, w);   // drained FIFO still holds old words in memory
        assert (w == 32'd0) else begin
            $display("mismatch %s: empty DATA read expected 00000000 actual %08h", name, w);
            errors++;
        end
        wb_read(REG_STATUS, st);
        assert (st[0] == 1'b0) else begin
            $display("mismatch %s: non-empty flag after empty read expected 0 actual %0d",
                     name, st[0]);
            errors++;
        end
        assert (got_q.size() == exp_q.size()) else begin
            $display("mismatch %s: byte count expected %0d actual %0d",
                     name, exp_q.size(), got_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("mismatch %s: byte %0d expected %02h actual %02h",
                         name, i, exp_q[i], got_q[i]);
                errors++;
            end
        end
        exp_last = exp_q.size() % 4;
        if (exp_last == 0) begin
            exp_last = 4;
        end
        assert (last_cnt == exp_last) else begin
            $display("mismatch %s: last word bytes expected %0d actual %0d",
                     name, exp_last, last_cnt);
            errors++;
        end
        wb_read(REG_IN_TOTAL, in_tot);
        wb_read(REG_OUT_TOTAL, out_tot);
        assert (in_tot == 32'(in_cnt)) else begin
            $display("mismatch %s: IN_TOTAL expected %0d actual %0d", name, in_cnt, in_tot);
            errors++;
        end
        assert (out_tot == 32'(in_cnt + ff_cnt)) else begin
            $display("mismatch %s: OUT_TOTAL expected %0d actual %0d",
                     name, in_cnt + ff_cnt, out_tot);
            errors++;
        end
        clear_model();
    endtask

    task automatic check_after_reset();
        logic [31:0] st;
        logic [31:0] w;
        wb_read(REG_STATUS, st);
        assert (st == 32'd0) else begin
            $display("mismatch after_reset: STATUS expected 00000000 actual %08h", st);
            errors++;
        end
        wb_read(REG_DATA, w);   // empty FIFO reads as zero
        assert (w == 32'd0) else begin
            $display("mismatch after_reset: DATA expected 00000000 actual %08h", w);
            errors++;
        end
    endtask

    task automatic pass_plain_bytes();
        logic [31:0] w;
        for (int n = 0; n < 24; n++) begin
            w = $random(seed);
            for (int k = 0; k < 4; k++) begin
                if (w[8*k +: 8] == 8'hff) begin
                    w[8*k +: 8] = 8'hfe;
                end
            end
            send_word(w, 4);
        end
        close_segment("plain_bytes");
    endtask

    task automatic escape_every_lane();
        logic [31:0] w;
        logic [31:0] r;
        send_word(32'hff123456, 4);
        send_word(32'h12ff3456, 4);
        send_word(32'h1234ff56, 4);
        send_word(32'h123456ff, 4);   // zero spills into the next word
        send_word(32'h00ff00ff, 4);
        send_word(32'hffffffff, 4);
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            w = $random(seed);
            w[8*int'(r[1:0]) +: 8] = 8'hff;
            send_word(w, 4);
        end
        close_segment("ff_lanes");
    endtask

    task automatic pack_partial_words();
        logic [31:0] w;
        logic [31:0] r;
        send_word(32'hab000000, 1);
        send_word(32'h12ff0000, 2);
        send_word(32'hff34ff00, 3);
        for (int n = 0; n < 16; n++) begin
            r = $random(seed);
            w = $random(seed);
            if (r[4]) begin
                w[31:24] = 8'hff;
            end
            send_word(w, int'(r[1:0]) + 1);
        end
        send_word(32'hff000000, 1);   // pending zero at flush
        close_segment("partial_words");
    endtask

    task automatic stall_on_ff_burst();
        int stalls_before;
        stalls_before = stalls;
        for (int n = 0; n < 40; n++) begin
            send_word(32'hffffffff, 4);
        end
        assert (stalls > stalls_before) else begin
            $display("ff_burst: the bus never held off a write while the output FIFO filled");
            errors++;
        end
        close_segment("ff_burst");
    endtask

    initial begin
        seed      = 69877;
        errors    = 0;
        timeouts  = 0;
        stalls    = 0;
        cur_bytes = 4;   // BYTES resets to 0 for full words
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdata  = 32'd0;
        clear_model();
        repeat (10) @(posedge xclk);
        rst <= 1'b0;

        check_after_reset();
        pass_plain_bytes();
        escape_every_lane();
        pack_partial_words();
        stall_on_ff_burst();

        repeat (5) @(posedge xclk);
        $display("errors: %0d, timeouts: %0d, write stalls: %0d", errors, timeouts, stalls);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* jpeg_stuff.f */
+incdir+rtl
rtl/stuff_pkg.sv
rtl/wb_pkg.sv
rtl/stream_if.sv
rtl/stream_fifo.sv
rtl/ff_escape.sv
rtl/stuff_byte_counter.sv
rtl/wb_stuff_ctrl.sv
rtl/stuff_top.sv
tb/tb_stuff_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f jpeg_stuff.f --top-module tb_stuff_top -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
